// File: hdl/seq_daq_macros.svh
`ifndef SEQ_DAQ_MACROS_SVH
`define SEQ_DAQ_MACROS_SVH

// gpio window, leds and dip switches
`define GPIO_BASE 32'h0000_0000
`define GPIO_HIGH 32'h0000_000f

// sequencer window, 16 registers then pattern memory
`define SEQ_BASE 32'h0000_1000
`define SEQ_HIGH 32'h0000_110f

// pattern memory depth in words
`define SEQ_DEPTH 256

// first memory byte inside the seq window
`define SEQ_MEM_OFS 9'd16

// sequencer register offsets
`define SEQ_REG_START  9'd0
`define SEQ_REG_STATUS 9'd1
`define SEQ_REG_SIZE   9'd2
`define SEQ_REG_DIV    9'd3

`endif

// File: hdl/seq_daq_pkg.sv
package seq_daq_pkg;

    typedef logic [31:0] rbcp_addr_t;   // rbcp byte address from the network side
    typedef logic [7:0]  byte_t;        // bus data
    typedef logic [8:0]  loc_addr_t;    // offset inside one peripheral window

    // request from the bridge to one peripheral
    typedef struct packed {
        logic      wr;      // write strobe, one cycle
        logic      rd;      // read strobe, one cycle
        loc_addr_t addr;    // offset from window base
        byte_t     wdata;   // write byte
    } bus_req_t;

    // one pattern word as driven onto the chip control lines
    typedef struct packed {
        logic [1:0] spare;          // unused pattern bits
        logic       inject;         // charge injection pulse
        logic       pixel_sr_en;    // gates pixel_sr_clk
        logic       global_dac_ld;  // dac load strobe
        logic       global_ctr_ld;  // counter load strobe
        logic       global_sr_en;   // gates global_sr_clk
        logic       sr_in;          // serial data into both shift regs
    } seq_word_t;

    // step engine states
    typedef enum logic [1:0] {
        st_idle = 2'd0,     // after reset, nothing played yet
        st_run  = 2'd1,     // stepping through memory
        st_done = 2'd2      // last step finished, done flag up
    } seq_state_t;

endpackage

// File: hdl/rbcp_bridge.sv
`timescale 1ns/1ns
`include "seq_daq_macros.svh"

module rbcp_bridge (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  logic                  rbcp_act,
    input  logic                  rbcp_we,
    input  logic                  rbcp_re,
    input  seq_daq_pkg::rbcp_addr_t rbcp_addr,
    input  seq_daq_pkg::byte_t    rbcp_wd,
    input  seq_daq_pkg::byte_t    gpio_rdata,
    input  seq_daq_pkg::byte_t    seq_rdata,
    output logic                  rbcp_ack,
    output seq_daq_pkg::byte_t    rbcp_rd,
    output seq_daq_pkg::bus_req_t gpio_req,
    output seq_daq_pkg::bus_req_t seq_req
);
    import seq_daq_pkg::*;

    logic       wr_act;     // write strobe qualified by act
    logic       rd_act;     // read strobe qualified by act
    rbcp_addr_t gpio_ofs;   // address relative to gpio base
    rbcp_addr_t seq_ofs;    // address relative to seq base
    logic       gpio_hit;
    logic       seq_hit;
    logic [1:0] sel_q1;     // window select, bit0 gpio bit1 seq
    logic [1:0] sel_q2;     // same, aligned with peripheral rdata
    logic       acc_q1;     // access in flight, bus strobe stage
    logic       acc_q2;     // access in flight, rdata stage

    assign wr_act = rbcp_act & rbcp_we;
    assign rd_act = rbcp_act & rbcp_re;

    // wrapping subtract also catches addresses below base
    assign gpio_ofs = rbcp_addr - `GPIO_BASE;
    assign seq_ofs  = rbcp_addr - `SEQ_BASE;
    assign gpio_hit = gpio_ofs <= (`GPIO_HIGH - `GPIO_BASE);
    assign seq_hit  = seq_ofs <= (`SEQ_HIGH - `SEQ_BASE);

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_req <= '0;
            seq_req  <= '0;
            sel_q1   <= '0;
            acc_q1   <= 1'b0;
        end else begin
            gpio_req.wr    <= wr_act & gpio_hit;    // only the hit window sees a strobe
            gpio_req.rd    <= rd_act & gpio_hit;
            gpio_req.addr  <= loc_addr_t'(gpio_ofs);
            gpio_req.wdata <= rbcp_wd;
            seq_req.wr     <= wr_act & seq_hit;
            seq_req.rd     <= rd_act & seq_hit;
            seq_req.addr   <= loc_addr_t'(seq_ofs);
            seq_req.wdata  <= rbcp_wd;
            sel_q1         <= {seq_hit, gpio_hit};
            acc_q1         <= wr_act | rd_act;      // unmapped accesses still ack
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_q2   <= '0;
            acc_q2   <= 1'b0;
            rbcp_ack <= 1'b0;
            rbcp_rd  <= '0;
        end else begin
            sel_q2   <= sel_q1;
            acc_q2   <= acc_q1;
            rbcp_ack <= acc_q2;                     // t+3 pulse
            if (acc_q2) begin
                if (sel_q2[0])
                    rbcp_rd <= gpio_rdata;
                else if (sel_q2[1])
                    rbcp_rd <= seq_rdata;
                else
                    rbcp_rd <= '0;                  // no window, read zero
            end
        end
    end

endmodule

// File: hdl/gpio_regs.sv
`timescale 1ns/1ns

module gpio_regs (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  seq_daq_pkg::bus_req_t req,
    input  logic [3:0]            dip,
    output seq_daq_pkg::byte_t    rdata,
    output logic [3:0]            led
);
    import seq_daq_pkg::*;

    localparam loc_addr_t IO_OFS = 9'd0;   // single io register

    logic [3:0] dip_meta;   // first sync stage
    logic [3:0] dip_sync;   // settled switch value
    logic       io_sel;

    assign io_sel = (req.addr == IO_OFS);

    // switches are asynchronous to bus_clk
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            dip_meta <= '0;
            dip_sync <= '0;
        end else begin
            dip_meta <= dip;
            dip_sync <= dip_meta;
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;                      // leds dark after reset
        end else if (req.wr && io_sel) begin
            led <= req.wdata[3:0];          // high nibble ignored
        end
    end

    // read byte is ready the cycle after the strobe
    always_ff @(posedge bus_clk) begin
        if (req.rd) begin
            if (io_sel)
                rdata <= {dip_sync, led};   // dip high, led low
            else
                rdata <= '0;
        end
    end

endmodule

// File: hdl/seq_gen.sv
`timescale 1ns/1ns
`include "seq_daq_macros.svh"

module seq_gen (
    input  logic                   bus_clk,
    input  logic                   arst_n,
    input  seq_daq_pkg::bus_req_t  req,
    output seq_daq_pkg::byte_t     rdata,
    output seq_daq_pkg::seq_word_t seq_word,
    output logic                   step_phase,
    output logic                   seq_run
);
    import seq_daq_pkg::*;

    localparam int AW = $clog2(`SEQ_DEPTH);

    byte_t       mem [`SEQ_DEPTH];  // pattern memory
    byte_t       size_q;            // step count, 0 means full depth
    byte_t       div_q;             // each step lasts div+1 cycles
    seq_state_t  state;
    logic [AW:0] loaded;            // words put out so far this run
    byte_t       div_cnt;           // cycle inside the current step
    logic [AW:0] n_steps;
    logic [AW:0] ph_half;           // cycles of high phase
    logic [AW:0] ph_start;          // first cycle of high phase
    loc_addr_t   mem_ofs;
    logic [AW-1:0] mem_idx;
    logic        mem_hit;
    logic        start;
    logic        step_end;

    assign mem_hit = (req.addr >= `SEQ_MEM_OFS);
    assign mem_ofs = req.addr - `SEQ_MEM_OFS;
    assign mem_idx = mem_ofs[AW-1:0];

    // a start during a run is dropped
    assign start    = req.wr && (req.addr == `SEQ_REG_START) && (state != st_run);
    assign step_end = (div_cnt == div_q);
    assign n_steps  = (size_q == '0) ? (AW+1)'(`SEQ_DEPTH) : (AW+1)'(size_q);

    // high phase covers the last (div+1)/2 cycles of a step
    assign ph_half    = ((AW+1)'(div_q) + 1'b1) >> 1;
    assign ph_start   = (AW+1)'(div_q) + 1'b1 - ph_half;
    assign seq_run    = (state == st_run);
    assign step_phase = seq_run && ((AW+1)'(div_cnt) >= ph_start);

    always_ff @(posedge bus_clk) begin
        if (req.wr && mem_hit)
            mem[mem_idx] <= req.wdata;
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            size_q <= '0;
            div_q  <= '0;
        end else if (req.wr) begin
            case (req.addr)
                `SEQ_REG_SIZE: size_q <= req.wdata;
                `SEQ_REG_DIV:  div_q  <= req.wdata;
                default: ;
            endcase
        end
    end

    // bus read port, one cycle latency
    always_ff @(posedge bus_clk) begin
        if (req.rd) begin
            if (mem_hit) begin
                rdata <= mem[mem_idx];
            end else begin
                case (req.addr)
                    `SEQ_REG_STATUS: rdata <= {6'b0, seq_run, state == st_done};
                    `SEQ_REG_SIZE:   rdata <= size_q;
                    `SEQ_REG_DIV:    rdata <= div_q;
                    default:         rdata <= '0;   // start reads zero
                endcase
            end
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            loaded   <= '0;
            div_cnt  <= '0;
            seq_word <= '0;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        state    <= st_run;         // also clears done
                        seq_word <= seq_word_t'(mem[0]);
                        loaded   <= (AW+1)'(1);
                        div_cnt  <= '0;
                    end
                end
                st_run: begin
                    if (step_end) begin
                        div_cnt <= '0;
                        if (loaded == n_steps) begin
                            state    <= st_done;
                            seq_word <= '0;         // lines idle after the last step
                        end else begin
                            seq_word <= seq_word_t'(mem[loaded[AW-1:0]]);
                            loaded   <= loaded + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: hdl/sr_driver.sv
`timescale 1ns/1ns

module sr_driver (
    input  logic                   bus_clk,
    input  logic                   arst_n,
    input  seq_daq_pkg::seq_word_t seq_word,
    input  logic                   step_phase,
    input  logic                   seq_run,
    output logic                   sr_in,
    output logic                   global_ctr_ld,
    output logic                   global_dac_ld,
    output logic                   inject,
    output logic                   global_sr_clk,
    output logic                   pixel_sr_clk
);

    logic glb_gate;     // global clock wanted this cycle
    logic pix_gate;     // pixel clock wanted this cycle

    // and of enable and phase, registered below
    assign glb_gate = seq_run & step_phase & seq_word.global_sr_en;
    assign pix_gate = seq_run & step_phase & seq_word.pixel_sr_en;

    // every pin comes straight from a flop
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            sr_in         <= 1'b0;
            global_ctr_ld <= 1'b0;
            global_dac_ld <= 1'b0;
            inject        <= 1'b0;
            global_sr_clk <= 1'b0;
            pixel_sr_clk  <= 1'b0;
        end else begin
            sr_in         <= seq_run & seq_word.sr_in;          // held low when idle
            global_ctr_ld <= seq_run & seq_word.global_ctr_ld;
            global_dac_ld <= seq_run & seq_word.global_dac_ld;
            inject        <= seq_run & seq_word.inject;
            global_sr_clk <= glb_gate;      // one pulse per enabled step
            pixel_sr_clk  <= pix_gate;
        end
    end

endmodule

// File: hdl/seq_daq_top.sv
`timescale 1ns/1ns

module seq_daq_top (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  logic                    rbcp_act,
    input  logic                    rbcp_we,
    input  logic                    rbcp_re,
    input  seq_daq_pkg::rbcp_addr_t rbcp_addr,
    input  seq_daq_pkg::byte_t      rbcp_wd,
    input  logic [3:0]              dip,
    output logic                    rbcp_ack,
    output seq_daq_pkg::byte_t      rbcp_rd,
    output logic [3:0]              led,
    output logic                    sr_in,
    output logic                    global_ctr_ld,
    output logic                    global_dac_ld,
    output logic                    inject,
    output logic                    global_sr_clk,
    output logic                    pixel_sr_clk
);
    import seq_daq_pkg::*;

    bus_req_t  gpio_req;    // bridge to gpio
    bus_req_t  seq_req;     // bridge to sequencer
    byte_t     gpio_rdata;
    byte_t     seq_rdata;
    seq_word_t seq_word;    // current pattern word
    logic      step_phase;
    logic      seq_run;

    rbcp_bridge u_bridge (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .rbcp_act   (rbcp_act),
        .rbcp_we    (rbcp_we),
        .rbcp_re    (rbcp_re),
        .rbcp_addr  (rbcp_addr),
        .rbcp_wd    (rbcp_wd),
        .gpio_rdata (gpio_rdata),
        .seq_rdata  (seq_rdata),
        .rbcp_ack   (rbcp_ack),
        .rbcp_rd    (rbcp_rd),
        .gpio_req   (gpio_req),
        .seq_req    (seq_req)
    );

    gpio_regs u_gpio (
        .bus_clk (bus_clk),
        .arst_n  (arst_n),
        .req     (gpio_req),
        .dip     (dip),
        .rdata   (gpio_rdata),
        .led     (led)
    );

    seq_gen u_seq (
        .bus_clk    (bus_clk),
        .arst_n     (arst_n),
        .req        (seq_req),
        .rdata      (seq_rdata),
        .seq_word   (seq_word),
        .step_phase (step_phase),
        .seq_run    (seq_run)
    );

    sr_driver u_sr (
        .bus_clk       (bus_clk),
        .arst_n        (arst_n),
        .seq_word      (seq_word),
        .step_phase    (step_phase),
        .seq_run       (seq_run),
        .sr_in         (sr_in),
        .global_ctr_ld (global_ctr_ld),
        .global_dac_ld (global_dac_ld),
        .inject        (inject),
        .global_sr_clk (global_sr_clk),
        .pixel_sr_clk  (pixel_sr_clk)
    );

endmodule

// File: test/seq_daq_chk.sv
`timescale 1ns/1ns

module seq_daq_chk (
    input logic                  bus_clk,
    input logic                  arst_n,
    input logic                  rbcp_ack,
    input seq_daq_pkg::bus_req_t gpio_req,
    input seq_daq_pkg::bus_req_t seq_req,
    input logic                  seq_run,
    input logic                  global_sr_clk,
    input logic                  pixel_sr_clk
);

    int         fail_cnt = 0;   // assertion failures so far
    logic [3:0] strobes;        // every bus strobe in one vector

    assign strobes = {gpio_req.wr, gpio_req.rd, seq_req.wr, seq_req.rd};

    ack_pulse: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rbcp_ack |=> !rbcp_ack)
        else begin
            $error("rbcp_ack high for more than one cycle");
            fail_cnt++;
        end

    one_strobe: assert property (@(posedge bus_clk) disable iff (!arst_n)
        $onehot0(strobes))
        else begin
            $error("two bus strobes in the same cycle");
            fail_cnt++;
        end

    // clocks lag seq_run by the output register
    clk_in_run: assert property (@(posedge bus_clk) disable iff (!arst_n)
        (global_sr_clk || pixel_sr_clk) |-> $past(seq_run))
        else begin
            $error("shift clock high outside a run");
            fail_cnt++;
        end

endmodule

bind seq_daq_top seq_daq_chk u_chk (
    .bus_clk       (bus_clk),
    .arst_n        (arst_n),
    .rbcp_ack      (rbcp_ack),
    .gpio_req      (gpio_req),
    .seq_req       (seq_req),
    .seq_run       (seq_run),
    .global_sr_clk (global_sr_clk),
    .pixel_sr_clk  (pixel_sr_clk)
);

// File: test/tb_seq_daq.sv
`timescale 1ns/1ns
`include "seq_daq_macros.svh"

module tb_seq_daq;
    import seq_daq_pkg::*;

    localparam int N_LED    = 16;
    localparam int N_UNMAP  = 16;
    localparam int N_ACCESS = 2 * N_LED + 2 * N_UNMAP + 2 * `SEQ_DEPTH + 25;
    localparam int RUN_MAX  = `SEQ_DEPTH * 5 + 8;      // full depth at div 4
    localparam int LIMIT_NS = 4 * (N_ACCESS * 8 + 3 * RUN_MAX + 200);

    logic       bus_clk;
    logic       arst_n;
    logic       rbcp_act;
    logic       rbcp_we;
    logic       rbcp_re;
    rbcp_addr_t rbcp_addr;
    byte_t      rbcp_wd;
    logic [3:0] dip;
    logic       rbcp_ack;
    byte_t      rbcp_rd;
    logic [3:0] led;
    logic       sr_in;
    logic       global_ctr_ld;
    logic       global_dac_ld;
    logic       inject;
    logic       global_sr_clk;
    logic       pixel_sr_clk;

    logic [31:0] lfsr;                  // random state
    byte_t       mem_model [`SEQ_DEPTH];
    logic [3:0]  led_model;
    logic [3:0]  dip_model;
    byte_t       size_model;
    byte_t       div_model;
    int          errors;
    int          checks;

    seq_daq_top u_dut (.*);

    initial begin
        bus_clk = 1'b0;
        forever #2 bus_clk = ~bus_clk;  // 4 ns period
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // gpio window starts at address zero
    function automatic logic in_window(input rbcp_addr_t a);
        return (a <= `GPIO_HIGH) || (a >= `SEQ_BASE && a <= `SEQ_HIGH);
    endfunction

    // inject, dac_ld, ctr_ld, sr_in from a pattern byte
    function automatic logic [3:0] word_lines(input byte_t w);
        return {w[5], w[3], w[2], w[0]};
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic test_done(input int id, input string name, input int err0);
        $display("test %0d %s: %s", id, name, (errors == err0) ? "ok" : "errors seen");
    endtask

    // one rbcp access, ack must come exactly 3 cycles after the strobe
    task automatic rbcp_access(input logic wr, input rbcp_addr_t addr, input byte_t wd,
                               output byte_t rd);
        int n;
        @(posedge bus_clk);
        rbcp_act  <= 1'b1;
        rbcp_we   <= wr;
        rbcp_re   <= ~wr;
        rbcp_addr <= addr;
        rbcp_wd   <= wd;
        @(posedge bus_clk);
        rbcp_act <= 1'b0;               // single-cycle strobe
        rbcp_we  <= 1'b0;
        rbcp_re  <= 1'b0;
        n = 1;
        @(negedge bus_clk);
        while (!rbcp_ack && n < 16) begin
            @(negedge bus_clk);
            n++;
        end
        if (!rbcp_ack) begin
            errors++;
            $display("no ack from the bridge for address %h at %0t ns", addr, $time);
        end else begin
            check_val(32'(n), 32'd3, "ack latency");
        end
        rd = rbcp_rd;
    endtask

    task automatic bus_write(input rbcp_addr_t addr, input byte_t wd);
        byte_t unused;
        rbcp_access(1'b1, addr, wd, unused);
    endtask

    task automatic read_expect(input rbcp_addr_t addr, input byte_t exp, input string what);
        byte_t rd;
        rbcp_access(1'b0, addr, 8'h00, rd);
        check_val(32'(rd), 32'(exp), what);
    endtask

    // j counts negedges from the edge that drives the start strobe
    // word k is on the pins from j = 4 + k*step
    task automatic watch_run(input int n, input int step, output int glb_edges,
                             output int pix_edges);
        logic [3:0] exp_lines;
        logic       glb_q;
        logic       pix_q;
        glb_edges = 0;
        pix_edges = 0;
        glb_q     = 1'b0;
        pix_q     = 1'b0;
        @(posedge bus_clk);
        for (int j = 1; j <= 4 + n * step + 2; j++) begin
            @(negedge bus_clk);
            exp_lines = 4'h0;           // idle outside the run
            if (j >= 4 && j < 4 + n * step)
                exp_lines = word_lines(mem_model[(j - 4) / step]);
            check_val(32'({inject, global_dac_ld, global_ctr_ld, sr_in}), 32'(exp_lines),
                      "control lines");
            if (global_sr_clk && !glb_q)
                glb_edges++;
            if (pixel_sr_clk && !pix_q)
                pix_edges++;
            glb_q = global_sr_clk;
            pix_q = pixel_sr_clk;
        end
    endtask

    task automatic run_test(input int id, input string name, input logic restart);
        int n;
        int step;
        int glb;
        int pix;
        int exp_glb;
        int exp_pix;
        int err0;
        err0       = errors;
        size_model = byte_t'(rand_bits(8));
        div_model  = byte_t'(32'd1 + rand_bits(2));    // div 1 to 4
        if (restart)
            size_model[7] = 1'b1;       // long enough to hit mid-run
        bus_write(`SEQ_BASE + 32'(`SEQ_REG_SIZE), size_model);
        bus_write(`SEQ_BASE + 32'(`SEQ_REG_DIV), div_model);
        n       = (size_model == 8'd0) ? `SEQ_DEPTH : int'(size_model);
        step    = int'(div_model) + 1;
        exp_glb = 0;
        exp_pix = 0;
        for (int k = 0; k < n; k++) begin
            exp_glb += int'(mem_model[k][1]);   // global_sr_en
            exp_pix += int'(mem_model[k][4]);   // pixel_sr_en
        end
        fork
            begin
                bus_write(`SEQ_BASE + 32'(`SEQ_REG_START), 8'h01);
                if (restart)
                    bus_write(`SEQ_BASE + 32'(`SEQ_REG_START), 8'h01);   // must be dropped
            end
            watch_run(n, step, glb, pix);
        join
        check_val(32'(glb), 32'(exp_glb), "global_sr_clk edges");
        check_val(32'(pix), 32'(exp_pix), "pixel_sr_clk edges");
        read_expect(`SEQ_BASE + 32'(`SEQ_REG_STATUS), 8'h01, "status done after run");
        test_done(id, name, err0);
    endtask

    initial begin
        byte_t      wd;
        rbcp_addr_t addr;
        int         err0;
        lfsr       = 32'h66003f83;
        errors     = 0;
        checks     = 0;
        led_model  = '0;
        dip_model  = '0;
        size_model = '0;
        div_model  = '0;
        arst_n    <= 1'b0;
        rbcp_act  <= 1'b0;
        rbcp_we   <= 1'b0;
        rbcp_re   <= 1'b0;
        rbcp_addr <= '0;
        rbcp_wd   <= '0;
        dip       <= '0;
        repeat (8) @(posedge bus_clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge bus_clk);

        err0 = errors;
        for (int i = 0; i < N_LED; i++) begin
            wd = byte_t'(rand_bits(8));
            bus_write(`GPIO_BASE, wd);
            led_model = wd[3:0];
            dip_model = 4'(rand_bits(4));
            @(posedge bus_clk);
            dip <= dip_model;
            repeat (2) @(posedge bus_clk);  // through both sync flops
            read_expect(`GPIO_BASE, {dip_model, led_model}, "gpio readback");
            check_val(32'(led), 32'(led_model), "led port");
        end
        test_done(1, "led and dip", err0);

        err0 = errors;
        for (int i = 0; i < N_UNMAP; i++) begin
            case (i)
                0: addr = `GPIO_HIGH + 32'd1;   // window edges first
                1: addr = `SEQ_BASE - 32'd1;
                2: addr = `SEQ_HIGH + 32'd1;
                default: addr = rand_bits(32);
            endcase
            while (in_window(addr))
                addr = rand_bits(32);
            read_expect(addr, 8'h00, "unmapped read");
            bus_write(addr, byte_t'(rand_bits(8)));
        end
        read_expect(`GPIO_BASE, {dip_model, led_model}, "gpio after unmapped writes");
        read_expect(`SEQ_BASE + 32'(`SEQ_REG_SIZE), size_model, "size after unmapped writes");
        read_expect(`SEQ_BASE + 32'(`SEQ_REG_DIV), div_model, "div after unmapped writes");
        test_done(2, "unmapped addresses", err0);

        err0 = errors;
        for (int i = 0; i < `SEQ_DEPTH; i++) begin
            mem_model[i] = byte_t'(rand_bits(8));
            bus_write(`SEQ_BASE + 32'(`SEQ_MEM_OFS) + 32'(i), mem_model[i]);
        end
        for (int i = 0; i < `SEQ_DEPTH; i++)
            read_expect(`SEQ_BASE + 32'(`SEQ_MEM_OFS) + 32'(i), mem_model[i], "pattern memory");
        size_model = byte_t'(rand_bits(8));
        div_model  = byte_t'(rand_bits(8));
        bus_write(`SEQ_BASE + 32'(`SEQ_REG_SIZE), size_model);
        bus_write(`SEQ_BASE + 32'(`SEQ_REG_DIV), div_model);
        read_expect(`SEQ_BASE + 32'(`SEQ_REG_SIZE), size_model, "size readback");
        read_expect(`SEQ_BASE + 32'(`SEQ_REG_DIV), div_model, "div readback");
        test_done(3, "memory and registers", err0);

        run_test(4, "pattern run", 1'b0);
        run_test(5, "shift clock count", 1'b0);
        run_test(6, "start during run", 1'b1);

        $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_chk.fail_cnt);
        if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bound by access count and longest runs
    initial begin
        #(LIMIT_NS);
        $display("watchdog expired after %0d ns, the run hangs", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: seq_daq.f
+incdir+hdl
hdl/seq_daq_pkg.sv
hdl/rbcp_bridge.sv
hdl/gpio_regs.sv
hdl/seq_gen.sv
hdl/sr_driver.sv
hdl/seq_daq_top.sv
test/seq_daq_chk.sv
test/tb_seq_daq.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_seq_daq
FILELIST  ?= seq_daq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
